//--- sparse_cu_params.svh
`ifndef SPARSE_CU_PARAMS_SVH
`define SPARSE_CU_PARAMS_SVH

////////////////////////////////////////
// Chunk and bus geometry
////////////////////////////////////////

// Byte positions per chunk
`define SCU_CHUNK_SIZE 32
// Byte positions per bus beat
`define SCU_BUS_SIZE 8
`define SCU_BEATS (`SCU_CHUNK_SIZE / `SCU_BUS_SIZE)
// Prefix counters must reach CHUNK_SIZE itself
`define SCU_PREFIX_SUM_SIZE 6

////////////////////////////////////////
// Output accumulators
////////////////////////////////////////

`define SCU_OUT_BUF_SIZE 32
`define SCU_OUT_BUF_NUM 8
`define SCU_BUF_SEL_W $clog2(`SCU_OUT_BUF_NUM)

`endif

//--- sparse_cu_pkg.sv
package sparse_cu_pkg;

	`include "sparse_cu_params.svh"

	////////////////////////////////////////
	// Payload types
	////////////////////////////////////////

	// Unsigned byte of ifm or filter
	typedef logic [7:0] data_t;

	// One bus beat
	typedef logic [`SCU_BUS_SIZE-1:0] beat_map_t;
	typedef data_t [`SCU_BUS_SIZE-1:0] beat_data_t;

	// Whole compressed chunk as map plus packed nonzero bytes
	typedef logic [`SCU_CHUNK_SIZE-1:0] chunk_map_t;
	typedef data_t [`SCU_CHUNK_SIZE-1:0] chunk_data_t;

	////////////////////////////////////////
	// Index and arithmetic types
	////////////////////////////////////////

	typedef logic [$clog2(`SCU_CHUNK_SIZE)-1:0] pos_t;
	typedef logic [`SCU_PREFIX_SUM_SIZE-1:0] psum_t;
	typedef logic [15:0] prod_t;
	typedef logic [`SCU_OUT_BUF_SIZE-1:0] acc_t;
	typedef logic [`SCU_BUF_SEL_W-1:0] buf_sel_t;

endpackage

//--- chunk_buffer.sv
`timescale 1ns/1ps

`include "sparse_cu_params.svh"

module chunk_buffer (
	 input  logic                      clk_i
	,input  logic                      rst_n_i
	,input  sparse_cu_pkg::beat_map_t  beat_map_i
	,input  sparse_cu_pkg::beat_data_t beat_data_i
	,input  logic                      wr_valid_i
	,input  logic                      wr_ready_i
	,input  logic                      release_i
	,output logic                      full_o
	,output sparse_cu_pkg::chunk_map_t map_o
	,output sparse_cu_pkg::chunk_data_t data_o
);

	import sparse_cu_pkg::*;

	localparam int BEATS = `SCU_BEATS;
	localparam int CNT_W = (BEATS > 1) ? $clog2(BEATS) : 1;

	logic [CNT_W-1:0] beat_cnt_q;
	logic             full_q;
	logic             beat_acc;
	logic             first_beat;
	logic             last_beat;
	int               beat_off;
	chunk_map_t       map_q;
	chunk_data_t      data_q;

	assign beat_acc   = wr_valid_i && wr_ready_i;
	assign first_beat = (beat_cnt_q == '0);
	assign last_beat  = (beat_cnt_q == CNT_W'(BEATS - 1));
	// Slice offset of the current beat, same for map and packed bytes
	assign beat_off   = int'(beat_cnt_q) * `SCU_BUS_SIZE;

	////////////////////////////////////////
	// Beat counter and full flag
	////////////////////////////////////////

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			beat_cnt_q <= '0;
			full_q     <= 1'b0;
		end else if (beat_acc) begin
			// A new load drops the old chunk
			if (first_beat)
				full_q <= 1'b0;
			if (last_beat) begin
				beat_cnt_q <= '0;
				full_q     <= 1'b1;
			end else begin
				beat_cnt_q <= beat_cnt_q + 1'b1;
			end
		end else if (release_i) begin
			full_q <= 1'b0;
		end
	end

	// Chunk storage
	always_ff @(posedge clk_i) begin
		if (beat_acc) begin
			map_q[beat_off +: `SCU_BUS_SIZE]  <= beat_map_i;
			data_q[beat_off +: `SCU_BUS_SIZE] <= beat_data_i;
		end
	end

	assign full_o = full_q;
	assign map_o  = map_q;
	assign data_o = data_q;

endmodule

//--- input_selector.sv
`timescale 1ns/1ps

module input_selector (
	 input  logic                       clk_i
	,input  logic                       rst_n_i
	,input  sparse_cu_pkg::chunk_map_t  ifm_map_i
	,input  sparse_cu_pkg::chunk_map_t  filter_map_i
	,input  sparse_cu_pkg::chunk_data_t ifm_data_i
	,input  sparse_cu_pkg::chunk_data_t filter_data_i
	,input  logic                       step_i
	,input  logic                       scan_start_i
	,input  sparse_cu_pkg::pos_t        pos_i
	,output logic                       match_o
	,output sparse_cu_pkg::data_t       ifm_byte_o
	,output sparse_cu_pkg::data_t       filter_byte_o
);

	import sparse_cu_pkg::*;

	// Set bits seen so far in each map
	psum_t ifm_cnt_q;
	psum_t filter_cnt_q;

	// Prefix counts valid for the current position
	psum_t ifm_base;
	psum_t filter_base;

	logic  ifm_bit;
	logic  filter_bit;
	logic  hit;
	pos_t  ifm_idx;
	pos_t  filter_idx;
	logic  match_q;
	data_t ifm_byte_q;
	data_t filter_byte_q;

	////////////////////////////////////////
	// Position decode
	////////////////////////////////////////

	// First step of a scan comes together with scan start
	assign ifm_base    = scan_start_i ? '0 : ifm_cnt_q;
	assign filter_base = scan_start_i ? '0 : filter_cnt_q;

	assign ifm_bit    = ifm_map_i[pos_i];
	assign filter_bit = filter_map_i[pos_i];
	assign hit        = step_i && ifm_bit && filter_bit;

	// Index into the packed nonzero list
	assign ifm_idx    = pos_t'(ifm_base);
	assign filter_idx = pos_t'(filter_base);

	////////////////////////////////////////
	// Prefix counters
	////////////////////////////////////////

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ifm_cnt_q    <= '0;
			filter_cnt_q <= '0;
		end else if (step_i) begin
			ifm_cnt_q    <= ifm_base + psum_t'(ifm_bit);
			filter_cnt_q <= filter_base + psum_t'(filter_bit);
		end else if (scan_start_i) begin
			ifm_cnt_q    <= '0;
			filter_cnt_q <= '0;
		end
	end

	////////////////////////////////////////
	// Matched pair register
	////////////////////////////////////////

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			match_q <= 1'b0;
		else
			match_q <= hit;
	end

	always_ff @(posedge clk_i) begin
		if (hit) begin
			ifm_byte_q    <= ifm_data_i[ifm_idx];
			filter_byte_q <= filter_data_i[filter_idx];
		end
	end

	assign match_o       = match_q;
	assign ifm_byte_o    = ifm_byte_q;
	assign filter_byte_o = filter_byte_q;

endmodule

//--- mac_acc_bank.sv
`timescale 1ns/1ps

`include "sparse_cu_params.svh"

module mac_acc_bank (
	 input  logic                    clk_i
	,input  logic                    rst_n_i
	,input  logic                    match_i
	,input  sparse_cu_pkg::data_t    ifm_byte_i
	,input  sparse_cu_pkg::data_t    filter_byte_i
	,input  sparse_cu_pkg::buf_sel_t acc_sel_i
	,input  sparse_cu_pkg::buf_sel_t out_sel_i
	,output sparse_cu_pkg::acc_t     out_dat_o
);

	import sparse_cu_pkg::*;

	prod_t prod_q;
	logic  prod_vld_q;
	acc_t  acc_q [`SCU_OUT_BUF_NUM];
	acc_t  out_q;

	// Multiply stage
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			prod_vld_q <= 1'b0;
		else
			prod_vld_q <= match_i;
	end

	always_ff @(posedge clk_i) begin
		if (match_i)
			prod_q <= prod_t'(ifm_byte_i) * prod_t'(filter_byte_i);
	end

	////////////////////////////////////////
	// Accumulators and read port
	////////////////////////////////////////

	// Sums wrap at the accumulator width
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `SCU_OUT_BUF_NUM; i++)
				acc_q[i] <= '0;
			out_q <= '0;
		end else begin
			if (prod_vld_q)
				acc_q[acc_sel_i] <= acc_q[acc_sel_i] + acc_t'(prod_q);
			out_q <= acc_q[out_sel_i];
		end
	end

	assign out_dat_o = out_q;

endmodule

//--- cu_control.sv
`timescale 1ns/1ps

`include "sparse_cu_params.svh"

module cu_control (
	 input  logic                    clk_i
	,input  logic                    rst_n_i
	,input  logic                    ifm_full_i
	,input  logic                    filter_full_i
	,input  sparse_cu_pkg::buf_sel_t acc_buf_sel_i
	,output logic                    ifm_ready_o
	,output logic                    filter_ready_o
	,output logic                    scan_start_o
	,output logic                    step_o
	,output sparse_cu_pkg::pos_t     pos_o
	,output sparse_cu_pkg::buf_sel_t acc_sel_o
	,output logic                    ifm_release_o
	,output logic                    sub_chunk_end_o
);

	import sparse_cu_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		SCAN,
		DRAIN,
		DONE
	} state_t;

	state_t   state_q;
	pos_t     pos_q;
	buf_sel_t acc_sel_q;
	logic     drain_q;
	logic     start;
	logic     last_pos;

	// Position 0 is stepped in the start cycle itself
	assign start    = (state_q == IDLE) && ifm_full_i && filter_full_i;
	assign last_pos = (pos_q == pos_t'(`SCU_CHUNK_SIZE - 1));

	////////////////////////////////////////
	// State, position and select
	////////////////////////////////////////

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q   <= IDLE;
			pos_q     <= '0;
			acc_sel_q <= '0;
			drain_q   <= 1'b0;
		end else begin
			// Wraps back to 0 after the last position
			if (step_o)
				pos_q <= pos_q + 1'b1;
			case (state_q)
				IDLE: begin
					if (start) begin
						acc_sel_q <= acc_buf_sel_i;
						state_q   <= SCAN;
					end
				end
				SCAN: begin
					if (last_pos)
						state_q <= DRAIN;
				end
				// Two cycles to flush the product and add stages
				DRAIN: begin
					drain_q <= ~drain_q;
					if (drain_q)
						state_q <= DONE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// Output decode
	assign scan_start_o    = start;
	assign step_o          = start || (state_q == SCAN);
	assign pos_o           = pos_q;
	assign acc_sel_o       = acc_sel_q;
	assign ifm_ready_o     = !ifm_full_i && (state_q == IDLE);
	assign filter_ready_o  = (state_q == IDLE) && !start;
	assign ifm_release_o   = (state_q == DONE);
	assign sub_chunk_end_o = (state_q == DONE);

endmodule

//--- compute_unit_top.sv
`timescale 1ns/1ps

module compute_unit_top (
	 input  logic                      clk_i
	,input  logic                      rst_n_i
	,input  sparse_cu_pkg::beat_map_t  ifm_sparsemap_i
	,input  sparse_cu_pkg::beat_map_t  filter_sparsemap_i
	,input  sparse_cu_pkg::beat_data_t ifm_nonzero_data_i
	,input  sparse_cu_pkg::beat_data_t filter_nonzero_data_i
	,input  logic                      ifm_chunk_wr_valid_i
	,input  logic                      filter_chunk_wr_valid_i
	,output logic                      ifm_wr_ready_o
	,output logic                      filter_wr_ready_o
	,output logic                      sub_chunk_end_o
	,input  sparse_cu_pkg::buf_sel_t   acc_buf_sel_i
	,input  sparse_cu_pkg::buf_sel_t   out_buf_sel_i
	,output sparse_cu_pkg::acc_t       out_buf_dat_o
);

	import sparse_cu_pkg::*;

	logic        ifm_full;
	logic        filter_full;
	logic        ifm_release;
	chunk_map_t  ifm_map;
	chunk_map_t  filter_map;
	chunk_data_t ifm_data;
	chunk_data_t filter_data;
	logic        scan_start;
	logic        step;
	pos_t        pos;
	buf_sel_t    acc_sel;
	logic        match;
	data_t       ifm_byte;
	data_t       filter_byte;

	////////////////////////////////////////
	// Input buffers
	////////////////////////////////////////

	chunk_buffer u_ifm_buf (
		 .clk_i       (clk_i)
		,.rst_n_i     (rst_n_i)
		,.beat_map_i  (ifm_sparsemap_i)
		,.beat_data_i (ifm_nonzero_data_i)
		,.wr_valid_i  (ifm_chunk_wr_valid_i)
		,.wr_ready_i  (ifm_wr_ready_o)
		,.release_i   (ifm_release)
		,.full_o      (ifm_full)
		,.map_o       (ifm_map)
		,.data_o      (ifm_data)
	);

	// Filter stays resident, only a new load replaces it
	chunk_buffer u_filter_buf (
		 .clk_i       (clk_i)
		,.rst_n_i     (rst_n_i)
		,.beat_map_i  (filter_sparsemap_i)
		,.beat_data_i (filter_nonzero_data_i)
		,.wr_valid_i  (filter_chunk_wr_valid_i)
		,.wr_ready_i  (filter_wr_ready_o)
		,.release_i   (1'b0)
		,.full_o      (filter_full)
		,.map_o       (filter_map)
		,.data_o      (filter_data)
	);

	////////////////////////////////////////
	// Datapath and control
	////////////////////////////////////////

	input_selector u_sel (
		 .clk_i         (clk_i)
		,.rst_n_i       (rst_n_i)
		,.ifm_map_i     (ifm_map)
		,.filter_map_i  (filter_map)
		,.ifm_data_i    (ifm_data)
		,.filter_data_i (filter_data)
		,.step_i        (step)
		,.scan_start_i  (scan_start)
		,.pos_i         (pos)
		,.match_o       (match)
		,.ifm_byte_o    (ifm_byte)
		,.filter_byte_o (filter_byte)
	);

	mac_acc_bank u_mac (
		 .clk_i         (clk_i)
		,.rst_n_i       (rst_n_i)
		,.match_i       (match)
		,.ifm_byte_i    (ifm_byte)
		,.filter_byte_i (filter_byte)
		,.acc_sel_i     (acc_sel)
		,.out_sel_i     (out_buf_sel_i)
		,.out_dat_o     (out_buf_dat_o)
	);

	cu_control u_ctrl (
		 .clk_i           (clk_i)
		,.rst_n_i         (rst_n_i)
		,.ifm_full_i      (ifm_full)
		,.filter_full_i   (filter_full)
		,.acc_buf_sel_i   (acc_buf_sel_i)
		,.ifm_ready_o     (ifm_wr_ready_o)
		,.filter_ready_o  (filter_wr_ready_o)
		,.scan_start_o    (scan_start)
		,.step_o          (step)
		,.pos_o           (pos)
		,.acc_sel_o       (acc_sel)
		,.ifm_release_o   (ifm_release)
		,.sub_chunk_end_o (sub_chunk_end_o)
	);

endmodule

//--- compute_unit_assertions.sv
`timescale 1ns/1ps

module compute_unit_assertions (
	 input logic clk_i
	,input logic rst_n_i
	,input logic scan_start_i
	,input logic ifm_wr_ready_i
	,input logic filter_wr_ready_i
	,input logic sub_chunk_end_i
);

	int   fail_cnt = 0;
	logic busy_q;

	// High from scan start until the end pulse
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			busy_q <= 1'b0;
		else if (sub_chunk_end_i)
			busy_q <= 1'b0;
		else if (scan_start_i)
			busy_q <= 1'b1;
	end

	////////////////////////////////////////
	// Handshake and pulse rules
	////////////////////////////////////////

	end_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		sub_chunk_end_i |=> !sub_chunk_end_i)
		else begin
			fail_cnt++;
			$error("sub_chunk_end_o was high for two cycles in a row");
		end

	filter_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(scan_start_i || busy_q) |-> !filter_wr_ready_i)
		else begin
			fail_cnt++;
			$error("filter_wr_ready_o was high during a scan");
		end

	ifm_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(scan_start_i || busy_q) |-> !ifm_wr_ready_i)
		else begin
			fail_cnt++;
			$error("ifm_wr_ready_o was high between scan start and end pulse");
		end

endmodule

bind compute_unit_top compute_unit_assertions u_assert (
	 .clk_i             (clk_i)
	,.rst_n_i           (rst_n_i)
	,.scan_start_i      (scan_start)
	,.ifm_wr_ready_i    (ifm_wr_ready_o)
	,.filter_wr_ready_i (filter_wr_ready_o)
	,.sub_chunk_end_i   (sub_chunk_end_o)
);

//--- compute_unit_tb.sv
`timescale 1ns/1ps

`include "sparse_cu_params.svh"

module compute_unit_tb;

	import sparse_cu_pkg::*;

	localparam int BUS     = `SCU_BUS_SIZE;
	localparam int CHUNK   = `SCU_CHUNK_SIZE;
	localparam int TIMEOUT = 500;

	logic        clk_i;
	logic        rst_n_i;
	beat_map_t   ifm_sparsemap_i;
	beat_map_t   filter_sparsemap_i;
	beat_data_t  ifm_nonzero_data_i;
	beat_data_t  filter_nonzero_data_i;
	logic        ifm_chunk_wr_valid_i;
	logic        filter_chunk_wr_valid_i;
	logic        ifm_wr_ready_o;
	logic        filter_wr_ready_o;
	logic        sub_chunk_end_o;
	buf_sel_t    acc_buf_sel_i;
	buf_sel_t    out_buf_sel_i;
	acc_t        out_buf_dat_o;

	integer      seed;
	int          err_cnt;
	int          timeout_cnt;
	// Expected accumulators and the uncompressed resident filter
	acc_t        model_acc [`SCU_OUT_BUF_NUM];
	chunk_data_t flt_dense;

	compute_unit_top dut (.*);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	////////////////////////////////////////
	// Model and stimulus helpers
	////////////////////////////////////////

	// Packs nonzero bytes in order and fills unused slots
	function automatic void compress(input chunk_data_t dense, output chunk_map_t map,
			output chunk_data_t nz);
		int n;
		n = 0;
		for (int p = 0; p < CHUNK; p++)
			nz[p] = data_t'(p * 37 + 8'h5a);
		for (int p = 0; p < CHUNK; p++) begin
			map[p] = (dense[p] != 8'h00);
			if (map[p]) begin
				nz[n] = dense[p];
				n++;
			end
		end
	endfunction

	function automatic acc_t expected_dot(input chunk_data_t ifm, input chunk_data_t flt);
		acc_t sum;
		sum = '0;
		for (int p = 0; p < CHUNK; p++)
			if (ifm[p] != 8'h00 && flt[p] != 8'h00)
				sum = sum + acc_t'(ifm[p]) * acc_t'(flt[p]);
		return sum;
	endfunction

	task automatic random_dense(input int zero_pct, output chunk_data_t dense);
		for (int p = 0; p < CHUNK; p++) begin
			if ($unsigned($random(seed)) % 100 < zero_pct)
				dense[p] = 8'h00;
			else
				dense[p] = data_t'($random(seed));
		end
	endtask

	task automatic compare_acc(input string name, input acc_t got, input acc_t exp);
		if (got !== exp) begin
			err_cnt++;
			$display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			err_cnt++;
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic finish_run();
		int assert_cnt;
		assert_cnt = dut.u_assert.fail_cnt;
		$display("Errors: %0d value, %0d assertion, %0d timeout",
			err_cnt, assert_cnt, timeout_cnt);
		if (err_cnt == 0 && assert_cnt == 0 && timeout_cnt == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	endtask

	task automatic abort_on_timeout(input string what);
		timeout_cnt++;
		$display("Timed out waiting for %s", what);
		finish_run();
	endtask

	////////////////////////////////////////
	// Driver tasks
	////////////////////////////////////////

	task automatic load_chunk(input logic is_filter, input chunk_data_t dense);
		chunk_map_t  map;
		chunk_data_t nz;
		int          waited;
		compress(dense, map, nz);
		for (int b = 0; b < `SCU_BEATS; b++) begin
			@(negedge clk_i);
			if (is_filter) begin
				filter_sparsemap_i      = map[b*BUS +: BUS];
				filter_nonzero_data_i   = nz[b*BUS +: BUS];
				filter_chunk_wr_valid_i = 1'b1;
			end else begin
				ifm_sparsemap_i      = map[b*BUS +: BUS];
				ifm_nonzero_data_i   = nz[b*BUS +: BUS];
				ifm_chunk_wr_valid_i = 1'b1;
			end
			waited = 0;
			while (!(is_filter ? filter_wr_ready_o : ifm_wr_ready_o)) begin
				@(negedge clk_i);
				waited++;
				if (waited > TIMEOUT)
					abort_on_timeout(is_filter ? "filter_wr_ready_o" : "ifm_wr_ready_o");
			end
			// Beat transfers on this edge
			@(posedge clk_i);
		end
		@(negedge clk_i);
		if (is_filter)
			filter_chunk_wr_valid_i = 1'b0;
		else
			ifm_chunk_wr_valid_i = 1'b0;
	endtask

	// Counts falling edges since the last beat
	task automatic wait_end(output int cycles);
		cycles = 0;
		while (sub_chunk_end_o !== 1'b1) begin
			@(negedge clk_i);
			cycles++;
			if (cycles > TIMEOUT)
				abort_on_timeout("sub_chunk_end_o");
		end
	endtask

	task automatic check_end_timing(input int cycles);
		if (cycles != CHUNK + 2) begin
			err_cnt++;
			$display("sub_chunk_end_o came %0d cycles after the last beat, not %0d",
				cycles, CHUNK + 2);
		end
	endtask

	task automatic read_acc(input buf_sel_t sel, output acc_t val);
		@(negedge clk_i);
		out_buf_sel_i = sel;
		@(negedge clk_i);
		val = out_buf_dat_o;
	endtask

	task automatic check_all_acc();
		acc_t val;
		for (int i = 0; i < `SCU_OUT_BUF_NUM; i++) begin
			read_acc(buf_sel_t'(i), val);
			compare_acc($sformatf("out_buf_dat_o[%0d]", i), val, model_acc[i]);
		end
	endtask

	task automatic run_ifm(input chunk_data_t dense, input buf_sel_t sel);
		int   cycles;
		acc_t val;
		acc_buf_sel_i = sel;
		load_chunk(1'b0, dense);
		wait_end(cycles);
		check_end_timing(cycles);
		model_acc[sel] = model_acc[sel] + expected_dot(dense, flt_dense);
		read_acc(sel, val);
		// Pulse is gone by now
		compare_bit("sub_chunk_end_o", sub_chunk_end_o, 1'b0);
		compare_acc($sformatf("out_buf_dat_o[%0d]", sel), val, model_acc[sel]);
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic reset_values();
		compare_bit("ifm_wr_ready_o", ifm_wr_ready_o, 1'b1);
		compare_bit("filter_wr_ready_o", filter_wr_ready_o, 1'b1);
		compare_bit("sub_chunk_end_o", sub_chunk_end_o, 1'b0);
		check_all_acc();
	endtask

	task automatic dense_dot_product();
		chunk_data_t ifm;
		for (int p = 0; p < CHUNK; p++) begin
			flt_dense[p] = data_t'(p + 1);
			ifm[p]       = data_t'(2 * p + 3);
		end
		load_chunk(1'b1, flt_dense);
		run_ifm(ifm, 0);
	endtask

	task automatic random_sparse_chunks();
		chunk_data_t ifm;
		random_dense(50, flt_dense);
		load_chunk(1'b1, flt_dense);
		for (int i = 1; i <= 3; i++) begin
			random_dense(60, ifm);
			run_ifm(ifm, buf_sel_t'(i));
		end
	endtask

	task automatic accumulate_chunks();
		chunk_data_t ifm;
		random_dense(40, ifm);
		run_ifm(ifm, 5);
		random_dense(40, ifm);
		run_ifm(ifm, 5);
		random_dense(40, ifm);
		run_ifm(ifm, 6);
		check_all_acc();
	endtask

	task automatic ifm_backpressure();
		chunk_data_t a;
		chunk_data_t b;
		int          cycles;
		acc_t        val;
		random_dense(50, a);
		random_dense(50, b);
		acc_buf_sel_i = 7;
		load_chunk(1'b0, a);
		fork
			load_chunk(1'b0, b);
			begin
				// Chunk b must stall for the whole scan of a
				compare_bit("ifm_wr_ready_o", ifm_wr_ready_o, 1'b0);
				wait_end(cycles);
				check_end_timing(cycles);
				model_acc[7] = model_acc[7] + expected_dot(a, flt_dense);
				read_acc(7, val);
				compare_acc("out_buf_dat_o[7]", val, model_acc[7]);
			end
		join
		wait_end(cycles);
		check_end_timing(cycles);
		model_acc[7] = model_acc[7] + expected_dot(b, flt_dense);
		check_all_acc();
	endtask

	task automatic filter_reload();
		chunk_data_t ifm;
		random_dense(30, flt_dense);
		load_chunk(1'b1, flt_dense);
		random_dense(30, ifm);
		run_ifm(ifm, 2);
		check_all_acc();
	endtask

	initial begin
		seed                    = 32'h498b1035;
		err_cnt                 = 0;
		timeout_cnt             = 0;
		rst_n_i                 = 1'b0;
		ifm_sparsemap_i         = '0;
		filter_sparsemap_i      = '0;
		ifm_nonzero_data_i      = '0;
		filter_nonzero_data_i   = '0;
		ifm_chunk_wr_valid_i    = 1'b0;
		filter_chunk_wr_valid_i = 1'b0;
		acc_buf_sel_i           = '0;
		out_buf_sel_i           = '0;
		for (int i = 0; i < `SCU_OUT_BUF_NUM; i++)
			model_acc[i] = '0;
		repeat (16) @(posedge clk_i);
		@(negedge clk_i);
		rst_n_i = 1'b1;
		@(negedge clk_i);
		reset_values();
		dense_dot_product();
		random_sparse_chunks();
		accumulate_chunks();
		ifm_backpressure();
		filter_reload();
		finish_run();
	end

endmodule

//--- sparse_cu.f
+incdir+.
sparse_cu_pkg.sv
chunk_buffer.sv
input_selector.sv
mac_acc_bank.sv
cu_control.sv
compute_unit_top.sv
compute_unit_assertions.sv
compute_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module compute_unit_tb \
	-f sparse_cu.f -o sim_compute_unit

out=$(./obj_dir/sim_compute_unit +verilator+error+limit+1000 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1
